//--- verilog/rvIsaPkg.sv
package rvIsaPkg;

	// Basic widths of the base integer ISA
	typedef logic [31:0] xlen_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0]  regIdx_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;

	// Immediate format selector
	typedef logic [2:0] immSel_t;

	// Common field layout, valid for the R format and partly for the others
	typedef struct packed {
		logic [6:0] funct7;
		regIdx_t    rs2;
		regIdx_t    rs1;
		funct3_t    funct3;
		regIdx_t    rd;
		opcode_t    opcode;
	} rFields_t;

	// Major opcodes
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OPIMM  = 7'b0010011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;

	// Arithmetic funct3 codes
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	// Branch funct3 codes
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam immSel_t IMM_I = 3'd0;
	localparam immSel_t IMM_S = 3'd1;
	localparam immSel_t IMM_B = 3'd2;
	localparam immSel_t IMM_U = 3'd3;
	localparam immSel_t IMM_J = 3'd4;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
	} aluOp_t;

	// Halt sequence: addi x1, x0, 12 then jalr x0, 0(x1)
	localparam xlen_t HALT_FIRST  = 32'h00c00093;
	localparam xlen_t HALT_SECOND = 32'h00008067;

endpackage

//--- verilog/rvCorePkg.sv
package rvCorePkg;

	import rvIsaPkg::*;

	typedef logic [11:0] byteAddr_t;
	typedef logic [11:0] wordAddr_t;
	typedef logic [3:0]  byteEn_t;
	typedef logic [1:0]  memSize_t;
	typedef logic [1:0]  wbSel_t;

	// Access sizes follow funct3[1:0] of loads and stores
	localparam memSize_t MEM_BYTE = 2'b00;
	localparam memSize_t MEM_HALF = 2'b01;
	localparam memSize_t MEM_WORD = 2'b10;

	localparam wbSel_t WB_ALU  = 2'd0;
	localparam wbSel_t WB_LOAD = 2'd1;
	localparam wbSel_t WB_PC4  = 2'd2;

	typedef struct packed {
		regIdx_t  rs1;
		regIdx_t  rs2;
		regIdx_t  rd;
		aluOp_t   aluOp;
		logic     useImm;
		logic     usePcA;
		logic     regWrite;
		logic     memRead;
		logic     memWrite;
		memSize_t memSize;
		logic     memUnsigned;
		logic     isBranch;
		funct3_t  branchFunct;
		logic     isJal;
		logic     isJalr;
		wbSel_t   wbSel;
	} ctrl_t;

	typedef struct packed {
		xlen_t   data;
		byteEn_t byteEn;
	} storeReq_t;

	typedef enum logic [1:0] {RUN, SAW_FIRST, HALTED} haltState_t;

endpackage

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile import rvIsaPkg::*; (
	input  logic    CLK,
	input  logic    RSTn,
	input  regIdx_t ra1,
	input  regIdx_t ra2,
	output xlen_t   rd1,
	output xlen_t   rd2,
	input  logic    we,
	input  regIdx_t wa,
	input  xlen_t   wd
);

	xlen_t regs [32];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// x0 is hardwired
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

//--- verilog/rvDecoder.sv
`timescale 1ns/1ps

module rvDecoder import rvIsaPkg::*, rvCorePkg::*; (
	input  instr_t instr,
	output ctrl_t  ctrl,
	output xlen_t  imm
);

	rFields_t f;
	immSel_t  immSel;

	assign f = instr;

	// alt selects SUB or SRA
	function automatic aluOp_t aluSel(funct3_t f3, logic alt);
		case (f3)
			F3_ADD:  aluSel = alt ? ALU_SUB : ALU_ADD;
			F3_SLL:  aluSel = ALU_SLL;
			F3_SLT:  aluSel = ALU_SLT;
			F3_SLTU: aluSel = ALU_SLTU;
			F3_XOR:  aluSel = ALU_XOR;
			F3_SR:   aluSel = alt ? ALU_SRA : ALU_SRL;
			F3_OR:   aluSel = ALU_OR;
			default: aluSel = ALU_AND;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		ctrl.rs1 = f.rs1;
		ctrl.rs2 = f.rs2;
		ctrl.rd = f.rd;
		ctrl.aluOp = ALU_ADD;
		ctrl.memSize = f.funct3[1:0];
		ctrl.memUnsigned = f.funct3[2];
		ctrl.branchFunct = f.funct3;
		ctrl.wbSel = WB_ALU;
		immSel = IMM_I;
		case (f.opcode)
			OPC_OP: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluSel(f.funct3, f.funct7[5]);
			end
			OPC_OPIMM: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				// funct7 only matters for SRAI, ADDI has no SUB form
				ctrl.aluOp = aluSel(f.funct3, f.funct7[5] && f.funct3 == F3_SR);
			end
			OPC_LOAD: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.wbSel = WB_LOAD;
			end
			OPC_STORE: begin
				ctrl.useImm = 1'b1;
				ctrl.memWrite = 1'b1;
				immSel = IMM_S;
			end
			OPC_BRANCH: begin
				ctrl.isBranch = 1'b1;
				ctrl.aluOp = ALU_SUB;
				immSel = IMM_B;
			end
			OPC_JAL: begin
				ctrl.regWrite = 1'b1;
				ctrl.isJal = 1'b1;
				ctrl.wbSel = WB_PC4;
				immSel = IMM_J;
			end
			OPC_JALR: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.isJalr = 1'b1;
				ctrl.wbSel = WB_PC4;
			end
			OPC_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.aluOp = ALU_PASSB;
				immSel = IMM_U;
			end
			OPC_AUIPC: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.usePcA = 1'b1;
				immSel = IMM_U;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (immSel)
			IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
			                instr[11:8], 1'b0};
			IMM_U:   imm = {instr[31:12], 12'b0};
			IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
			                instr[30:21], 1'b0};
			default: imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

endmodule

//--- verilog/rvAlu.sv
`timescale 1ns/1ps

module rvAlu import rvIsaPkg::*; (
	input  xlen_t   a,
	input  xlen_t   b,
	input  aluOp_t  op,
	input  funct3_t funct,
	output xlen_t   result,
	output logic    taken
);

	always_comb begin
		case (op)
			ALU_ADD:   result = a + b;
			ALU_SUB:   result = a - b;
			ALU_SLL:   result = a << b[4:0];
			ALU_SLT:   result = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU:  result = {31'b0, a < b};
			ALU_XOR:   result = a ^ b;
			ALU_SRL:   result = a >> b[4:0];
			ALU_SRA:   result = $signed(a) >>> b[4:0];
			ALU_OR:    result = a | b;
			ALU_AND:   result = a & b;
			ALU_PASSB: result = b;
			default:   result = '0;
		endcase
	end

	// Branch condition on the same operands
	always_comb begin
		case (funct)
			F3_BEQ:  taken = a == b;
			F3_BNE:  taken = a != b;
			F3_BLT:  taken = $signed(a) < $signed(b);
			F3_BGE:  taken = $signed(a) >= $signed(b);
			F3_BLTU: taken = a < b;
			F3_BGEU: taken = a >= b;
			default: taken = 1'b0;
		endcase
	end

endmodule

//--- verilog/lsuAlign.sv
`timescale 1ns/1ps

module lsuAlign import rvIsaPkg::*, rvCorePkg::*; (
	input  logic [1:0] addrLow,
	input  memSize_t   size,
	input  logic       isUnsigned,
	input  xlen_t      storeData,
	input  xlen_t      loadWord,
	output storeReq_t  store,
	output xlen_t      loadData
);

	logic [7:0]  loadByte;
	logic [15:0] loadHalf;

	// Store data is replicated, the byte enables pick the lanes
	always_comb begin
		case (size)
			MEM_BYTE: begin
				store.data = {4{storeData[7:0]}};
				store.byteEn = 4'b0001 << addrLow;
			end
			MEM_HALF: begin
				store.data = {2{storeData[15:0]}};
				store.byteEn = addrLow[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				store.data = storeData;
				store.byteEn = 4'b1111;
			end
		endcase
	end

	assign loadByte = loadWord[{addrLow, 3'b000} +: 8];
	assign loadHalf = loadWord[{addrLow[1], 4'b0000} +: 16];

	always_comb begin
		case (size)
			MEM_BYTE: loadData = {{24{!isUnsigned && loadByte[7]}}, loadByte};
			MEM_HALF: loadData = {{16{!isUnsigned && loadHalf[15]}}, loadHalf};
			default:  loadData = loadWord;
		endcase
	end

	// The core reports idle cycles as byte accesses, so only real accesses can fire
	accessAligned: assert final (!(size == MEM_HALF && addrLow[0]) &&
	                             !(size == MEM_WORD && addrLow != 2'b00))
		else $error("lsuAlign: misaligned access, size %0d offset %0d", size, addrLow);

endmodule

//--- verilog/haltMonitor.sv
`timescale 1ns/1ps

module haltMonitor import rvIsaPkg::*, rvCorePkg::*; (
	input  logic        CLK,
	input  logic        RSTn,
	input  instr_t      instr,
	input  logic        retire,
	output logic        halt,
	output logic [31:0] numInst
);

	haltState_t state;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			state <= RUN;
			numInst <= '0;
		end else if (retire) begin
			// The second halt word is still counted
			numInst <= numInst + 32'd1;
			case (state)
				RUN: begin
					if (instr == HALT_FIRST) state <= SAW_FIRST;
				end
				SAW_FIRST: begin
					if (instr == HALT_SECOND) state <= HALTED;
					else if (instr != HALT_FIRST) state <= RUN;
				end
				default: state <= state;
			endcase
		end
	end

	assign halt = (state == HALTED);

	haltSticky: assert property (@(posedge CLK) disable iff (RSTn)
		state == HALTED |=> state == HALTED)
		else $error("haltMonitor: left HALTED without reset");

endmodule

//--- verilog/riscvCore.sv
`timescale 1ns/1ps

module riscvCore import rvIsaPkg::*, rvCorePkg::*; #(
	parameter xlen_t RESET_PC = 32'h0000_0000
) (
	input  logic        CLK,
	input  logic        RSTn,
	output logic        iMemCsn,
	output byteAddr_t   iMemAddr,
	input  instr_t      iMemDi,
	output logic        dMemCsn,
	output logic        dMemWen,
	output wordAddr_t   dMemAddr,
	output xlen_t       dMemDout,
	output byteEn_t     dMemBe,
	input  xlen_t       dMemDi,
	output regIdx_t     rfRa1,
	output regIdx_t     rfRa2,
	input  xlen_t       rfRd1,
	input  xlen_t       rfRd2,
	output logic        rfWe,
	output regIdx_t     rfWa,
	output xlen_t       rfWd,
	output logic        halt,
	output logic [31:0] numInst
);

	xlen_t     pc, pcPlus4, pcImm, nextPc;
	xlen_t     imm, opA, opB, aluResult, loadData;
	ctrl_t     ctrl;
	storeReq_t store;
	memSize_t  lsuSize;
	logic      taken, memAccess, retire;

	// One instruction retires per edge until halt
	assign retire = !RSTn && !halt;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= RESET_PC;
		end else if (retire) begin
			pc <= nextPc;
		end
	end

	assign iMemCsn  = RSTn;
	assign iMemAddr = pc[11:0];

	rvDecoder dec0 (.instr(iMemDi), .ctrl(ctrl), .imm(imm));

	assign rfRa1 = ctrl.rs1;
	assign rfRa2 = ctrl.rs2;
	assign opA   = ctrl.usePcA ? pc : rfRd1;
	assign opB   = ctrl.useImm ? imm : rfRd2;

	rvAlu alu0 (
		.a(opA), .b(opB), .op(ctrl.aluOp), .funct(ctrl.branchFunct),
		.result(aluResult), .taken(taken)
	);

	// Next PC selection
	assign pcPlus4 = pc + 32'd4;
	assign pcImm   = pc + imm;

	always_comb begin
		if (ctrl.isJal) begin
			nextPc = pcImm;
		end else if (ctrl.isJalr) begin
			nextPc = {aluResult[31:1], 1'b0};
		end else if (ctrl.isBranch && taken) begin
			nextPc = pcImm;
		end else begin
			nextPc = pcPlus4;
		end
	end

	// Non-memory instructions reach the aligner as byte accesses
	assign memAccess = ctrl.memRead || ctrl.memWrite;
	assign lsuSize   = memAccess ? ctrl.memSize : MEM_BYTE;

	lsuAlign lsu0 (
		.addrLow(aluResult[1:0]), .size(lsuSize), .isUnsigned(ctrl.memUnsigned),
		.storeData(rfRd2), .loadWord(dMemDi), .store(store), .loadData(loadData)
	);

	assign dMemCsn  = !(memAccess && retire);
	assign dMemWen  = !(ctrl.memWrite && retire);
	assign dMemAddr = aluResult[13:2];
	assign dMemDout = store.data;
	assign dMemBe   = store.byteEn;

	// Write-back
	always_comb begin
		case (ctrl.wbSel)
			WB_LOAD: rfWd = loadData;
			WB_PC4:  rfWd = pcPlus4;
			default: rfWd = aluResult;
		endcase
	end

	assign rfWe = ctrl.regWrite && retire;
	assign rfWa = ctrl.rd;

	haltMonitor hmon0 (
		.CLK(CLK), .RSTn(RSTn), .instr(iMemDi), .retire(retire),
		.halt(halt), .numInst(numInst)
	);

	pcAligned: assert property (@(posedge CLK) disable iff (RSTn) pc[1:0] == 2'b00)
		else $error("riscvCore: PC %h is not word aligned", pc);

endmodule

//--- verilog/riscvTop.sv
`timescale 1ns/1ps

module riscvTop import rvIsaPkg::*, rvCorePkg::*; #(
	parameter xlen_t RESET_PC = 32'h0000_0000
) (
	input  logic        CLK,
	input  logic        RSTn,

	// Instruction memory
	output logic        iMemCsn,
	output byteAddr_t   iMemAddr,
	input  instr_t      iMemDi,

	// Data memory
	output logic        dMemCsn,
	output logic        dMemWen,
	output wordAddr_t   dMemAddr,
	output xlen_t       dMemDout,
	output byteEn_t     dMemBe,
	input  xlen_t       dMemDi,

	// Write-back trace
	output logic        rfWe,
	output regIdx_t     rfWa,
	output xlen_t       outputPort,

	output logic        halt,
	output logic [31:0] numInst
);

	regIdx_t rfRa1;
	regIdx_t rfRa2;
	xlen_t   rfRd1;
	xlen_t   rfRd2;

	riscvCore #(.RESET_PC(RESET_PC)) core0 (
		.CLK(CLK), .RSTn(RSTn),
		.iMemCsn(iMemCsn), .iMemAddr(iMemAddr), .iMemDi(iMemDi),
		.dMemCsn(dMemCsn), .dMemWen(dMemWen), .dMemAddr(dMemAddr),
		.dMemDout(dMemDout), .dMemBe(dMemBe), .dMemDi(dMemDi),
		.rfRa1(rfRa1), .rfRa2(rfRa2), .rfRd1(rfRd1), .rfRd2(rfRd2),
		.rfWe(rfWe), .rfWa(rfWa), .rfWd(outputPort),
		.halt(halt), .numInst(numInst)
	);

	// The trace port is the register file write data itself
	regFile rf0 (
		.CLK(CLK), .RSTn(RSTn),
		.ra1(rfRa1), .ra2(rfRa2), .rd1(rfRd1), .rd2(rfRd2),
		.we(rfWe), .wa(rfWa), .wd(outputPort)
	);

endmodule

//--- include/rvRefModel.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Expected effect of one retired instruction
typedef struct packed {
	logic      we;
	regIdx_t   wa;
	xlen_t     wd;
	logic      memRead;
	logic      memWrite;
	wordAddr_t addr;
	byteEn_t   be;
	xlen_t     sdata;
	xlen_t     nextPc;
} stepResult_t;

// Shadow architectural state
xlen_t  refRegs [32];
xlen_t  refMem [4096];
instr_t testProgram [$];

function automatic instr_t encR(funct3_t f3, logic [6:0] f7, regIdx_t rd, regIdx_t rs1,
		regIdx_t rs2);
	return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic instr_t encI(opcode_t opc, funct3_t f3, regIdx_t rd, regIdx_t rs1,
		logic [11:0] imm);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic instr_t encS(funct3_t f3, regIdx_t rs1, regIdx_t rs2, logic [11:0] imm);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic instr_t encB(funct3_t f3, regIdx_t rs1, regIdx_t rs2, logic [12:0] off);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic instr_t encU(opcode_t opc, regIdx_t rd, logic [19:0] imm);
	return {imm, rd, opc};
endfunction

function automatic instr_t encJ(regIdx_t rd, logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// Integer operation by funct3, alt picks SUB or SRA
function automatic xlen_t aluRef(funct3_t f3, logic alt, xlen_t a, xlen_t b);
	logic signed [31:0] sa;
	sa = a;
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'd3: return (a < b) ? 32'd1 : 32'd0;
		3'd4: return a ^ b;
		3'd5: begin
			if (alt) begin
				return sa >>> b[4:0];
			end
			return a >> b[4:0];
		end
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

// Executes one instruction on the shadow state
function automatic stepResult_t rvStep(xlen_t pc, instr_t ins);
	stepResult_t r;
	xlen_t       a, b;
	xlen_t       immI, immS, immB, immU, immJ;
	xlen_t       addr, word;
	funct3_t     f3;
	logic        alt;
	logic        cond;
	f3 = ins[14:12];
	a = refRegs[ins[19:15]];
	b = refRegs[ins[24:20]];
	immI = {{20{ins[31]}}, ins[31:20]};
	immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
	immU = {ins[31:12], 12'd0};
	immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
	r = '0;
	r.wa = ins[11:7];
	r.nextPc = pc + 32'd4;
	case (ins[6:0])
		OPC_LUI: begin
			r.we = 1'b1;
			r.wd = immU;
		end
		OPC_AUIPC: begin
			r.we = 1'b1;
			r.wd = pc + immU;
		end
		OPC_JAL: begin
			r.we = 1'b1;
			r.wd = pc + 32'd4;
			r.nextPc = pc + immJ;
		end
		OPC_JALR: begin
			r.we = 1'b1;
			r.wd = pc + 32'd4;
			r.nextPc = (a + immI) & ~32'd1;
		end
		OPC_BRANCH: begin
			case (f3)
				3'd0: cond = a == b;
				3'd1: cond = a != b;
				3'd4: cond = $signed(a) < $signed(b);
				3'd5: cond = $signed(a) >= $signed(b);
				3'd6: cond = a < b;
				3'd7: cond = a >= b;
				default: cond = 1'b0;
			endcase
			if (cond) begin
				r.nextPc = pc + immB;
			end
		end
		OPC_LOAD: begin
			addr = a + immI;
			r.we = 1'b1;
			r.memRead = 1'b1;
			r.addr = addr[13:2];
			word = refMem[addr[13:2]] >> {addr[1:0], 3'b000};
			case (f3)
				3'd0: r.wd = {{24{word[7]}}, word[7:0]};
				3'd1: r.wd = {{16{word[15]}}, word[15:0]};
				3'd4: r.wd = {24'd0, word[7:0]};
				3'd5: r.wd = {16'd0, word[15:0]};
				default: r.wd = word;
			endcase
		end
		OPC_STORE: begin
			addr = a + immS;
			r.memWrite = 1'b1;
			r.addr = addr[13:2];
			r.sdata = b << {addr[1:0], 3'b000};
			case (f3)
				3'd0: r.be = 4'b0001 << addr[1:0];
				3'd1: r.be = 4'b0011 << addr[1:0];
				default: r.be = 4'b1111;
			endcase
		end
		OPC_OPIMM: begin
			alt = (f3 == 3'd5) && ins[30];
			r.we = 1'b1;
			r.wd = aluRef(f3, alt, a, immI);
		end
		OPC_OP: begin
			r.we = 1'b1;
			r.wd = aluRef(f3, ins[30], a, b);
		end
		default: ;
	endcase
	if (r.we && r.wa != '0) begin
		refRegs[r.wa] = r.wd;
	end
	for (int k = 0; k < 4; k++) begin
		if (r.memWrite && r.be[k]) begin
			refMem[r.addr][8*k +: 8] = r.sdata[8*k +: 8];
		end
	end
	return r;
endfunction

// Test program, placed from address zero
function automatic void buildProgram();
	instr_t skip;
	skip = encI(OPC_OPIMM, 3'd0, 5'd7, 5'd0, 12'hfff);
	testProgram = {};
	testProgram.push_back(encU(OPC_LUI, 5'd1, 20'h80001));
	testProgram.push_back(encI(OPC_OPIMM, 3'd0, 5'd2, 5'd0, 12'hff9));
	testProgram.push_back(encI(OPC_OPIMM, 3'd0, 5'd3, 5'd0, 12'd5));
	testProgram.push_back(encR(3'd0, 7'h00, 5'd4, 5'd1, 5'd2));
	testProgram.push_back(encR(3'd0, 7'h20, 5'd5, 5'd3, 5'd2));
	testProgram.push_back(encR(3'd1, 7'h00, 5'd6, 5'd2, 5'd3));
	testProgram.push_back(encR(3'd2, 7'h00, 5'd7, 5'd2, 5'd3));
	testProgram.push_back(encR(3'd3, 7'h00, 5'd8, 5'd2, 5'd3));
	testProgram.push_back(encR(3'd4, 7'h00, 5'd9, 5'd1, 5'd2));
	testProgram.push_back(encR(3'd5, 7'h00, 5'd10, 5'd2, 5'd3));
	testProgram.push_back(encR(3'd5, 7'h20, 5'd11, 5'd2, 5'd3));
	testProgram.push_back(encR(3'd6, 7'h00, 5'd12, 5'd1, 5'd3));
	testProgram.push_back(encR(3'd7, 7'h00, 5'd13, 5'd1, 5'd2));
	testProgram.push_back(encI(OPC_OPIMM, 3'd1, 5'd14, 5'd3, 12'd29));
	testProgram.push_back(encI(OPC_OPIMM, 3'd5, 5'd15, 5'd1, 12'h404));
	testProgram.push_back(encI(OPC_OPIMM, 3'd5, 5'd16, 5'd1, 12'd4));
	testProgram.push_back(encI(OPC_OPIMM, 3'd2, 5'd17, 5'd2, 12'hfff));
	testProgram.push_back(encI(OPC_OPIMM, 3'd3, 5'd18, 5'd3, 12'hfff));
	testProgram.push_back(encI(OPC_OPIMM, 3'd4, 5'd19, 5'd2, 12'h555));
	testProgram.push_back(encI(OPC_OPIMM, 3'd6, 5'd20, 5'd3, 12'h0f0));
	testProgram.push_back(encI(OPC_OPIMM, 3'd7, 5'd21, 5'd2, 12'h7f0));
	testProgram.push_back(encU(OPC_AUIPC, 5'd22, 20'h12345));
	// x0 write, then read back through an add
	testProgram.push_back(encI(OPC_OPIMM, 3'd0, 5'd0, 5'd0, 12'd99));
	testProgram.push_back(encR(3'd0, 7'h00, 5'd23, 5'd0, 5'd0));
	// Lone first halt word must not stop the core
	testProgram.push_back(HALT_FIRST);
	testProgram.push_back(encI(OPC_OPIMM, 3'd0, 5'd24, 5'd0, 12'h200));
	testProgram.push_back(encS(3'd2, 5'd24, 5'd4, 12'd0));
	testProgram.push_back(encS(3'd1, 5'd24, 5'd2, 12'd6));
	testProgram.push_back(encS(3'd0, 5'd24, 5'd1, 12'd9));
	testProgram.push_back(encS(3'd0, 5'd24, 5'd3, 12'd11));
	testProgram.push_back(encI(OPC_LOAD, 3'd2, 5'd25, 5'd24, 12'd0));
	testProgram.push_back(encI(OPC_LOAD, 3'd1, 5'd26, 5'd24, 12'd6));
	testProgram.push_back(encI(OPC_LOAD, 3'd5, 5'd27, 5'd24, 12'd6));
	testProgram.push_back(encI(OPC_LOAD, 3'd0, 5'd28, 5'd24, 12'd9));
	testProgram.push_back(encI(OPC_LOAD, 3'd4, 5'd29, 5'd24, 12'd11));
	// Loads from untouched random words
	testProgram.push_back(encI(OPC_LOAD, 3'd0, 5'd30, 5'd24, 12'h31));
	testProgram.push_back(encI(OPC_LOAD, 3'd5, 5'd31, 5'd24, 12'h42));
	testProgram.push_back(encI(OPC_LOAD, 3'd1, 5'd5, 5'd24, 12'h52));
	testProgram.push_back(encI(OPC_LOAD, 3'd4, 5'd6, 5'd24, 12'h63));
	// Each branch kind taken once and not taken once
	testProgram.push_back(encB(3'd0, 5'd3, 5'd3, 13'd8));
	testProgram.push_back(skip);
	testProgram.push_back(encB(3'd0, 5'd2, 5'd3, 13'd8));
	testProgram.push_back(encB(3'd1, 5'd2, 5'd3, 13'd8));
	testProgram.push_back(skip);
	testProgram.push_back(encB(3'd1, 5'd3, 5'd3, 13'd8));
	testProgram.push_back(encB(3'd4, 5'd2, 5'd3, 13'd8));
	testProgram.push_back(skip);
	testProgram.push_back(encB(3'd4, 5'd3, 5'd2, 13'd8));
	testProgram.push_back(encB(3'd5, 5'd3, 5'd2, 13'd8));
	testProgram.push_back(skip);
	testProgram.push_back(encB(3'd5, 5'd2, 5'd3, 13'd8));
	testProgram.push_back(encB(3'd6, 5'd3, 5'd2, 13'd8));
	testProgram.push_back(skip);
	testProgram.push_back(encB(3'd6, 5'd2, 5'd3, 13'd8));
	testProgram.push_back(encB(3'd7, 5'd2, 5'd3, 13'd8));
	testProgram.push_back(skip);
	testProgram.push_back(encB(3'd7, 5'd3, 5'd2, 13'd8));
	testProgram.push_back(encJ(5'd8, 21'd12));
	testProgram.push_back(skip);
	testProgram.push_back(skip);
	// JALR target 0x109 drops bit zero and lands on 0x108
	testProgram.push_back(encI(OPC_OPIMM, 3'd0, 5'd9, 5'd0, 12'h105));
	testProgram.push_back(encI(OPC_JALR, 3'd0, 5'd10, 5'd9, 12'd4));
	testProgram.push_back(skip);
	testProgram.push_back(skip);
	testProgram.push_back(skip);
	testProgram.push_back(skip);
	testProgram.push_back(encI(OPC_OPIMM, 3'd0, 5'd11, 5'd10, 12'd1));
	testProgram.push_back(HALT_FIRST);
	testProgram.push_back(HALT_SECOND);
endfunction

`endif

//--- tests/tbRiscvTop.sv
`timescale 1ns/1ps

module tbRiscvTop import rvIsaPkg::*, rvCorePkg::*;;

	localparam xlen_t START_PC       = 32'h0000_0000;
	localparam int    TIMEOUT_CYCLES = 500;
	localparam int    HOLD_CYCLES    = 5;

	logic        CLK;
	logic        RSTn;
	logic        iMemCsn;
	byteAddr_t   iMemAddr;
	instr_t      iMemDi;
	logic        dMemCsn;
	logic        dMemWen;
	wordAddr_t   dMemAddr;
	xlen_t       dMemDout;
	byteEn_t     dMemBe;
	xlen_t       dMemDi;
	logic        rfWe;
	regIdx_t     rfWa;
	xlen_t       outputPort;
	logic        halt;
	logic [31:0] numInst;

	instr_t imem [1024];
	xlen_t  dmem [4096];
	integer seed;

	// Reference progress
	xlen_t refPc;
	int    retired;
	logic  sawFirst;
	logic  refHalted;

	`include "rvRefModel.svh"

	riscvTop #(.RESET_PC(START_PC)) dut0 (
		.CLK(CLK), .RSTn(RSTn),
		.iMemCsn(iMemCsn), .iMemAddr(iMemAddr), .iMemDi(iMemDi),
		.dMemCsn(dMemCsn), .dMemWen(dMemWen), .dMemAddr(dMemAddr),
		.dMemDout(dMemDout), .dMemBe(dMemBe), .dMemDi(dMemDi),
		.rfWe(rfWe), .rfWa(rfWa), .outputPort(outputPort),
		.halt(halt), .numInst(numInst)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Both memories answer combinationally
	assign iMemDi = imem[iMemAddr[11:2]];
	assign dMemDi = dmem[dMemAddr];

	always @(posedge CLK) begin
		if (!dMemCsn && !dMemWen) begin
			for (int k = 0; k < 4; k++) begin
				if (dMemBe[k]) begin
					dmem[dMemAddr][8*k +: 8] <= dMemDout[8*k +: 8];
				end
			end
		end
	end

	task automatic abortRun(string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkBit(string name, logic got, logic want);
		if (got !== want) begin
			abortRun($sformatf("CHECK FAILED %s got %h expected %h", name, got, want));
		end
	endtask

	task automatic checkWord(string name, xlen_t got, xlen_t want);
		if (got !== want) begin
			abortRun($sformatf("CHECK FAILED %s got %h expected %h", name, got, want));
		end
	endtask

	task automatic checkRegIdx(string name, regIdx_t got, regIdx_t want);
		if (got !== want) begin
			abortRun($sformatf("CHECK FAILED %s got %h expected %h", name, got, want));
		end
	endtask

	task automatic checkByteEn(string name, byteEn_t got, byteEn_t want);
		if (got !== want) begin
			abortRun($sformatf("CHECK FAILED %s got %h expected %h", name, got, want));
		end
	endtask

	task automatic checkWordAddr(string name, wordAddr_t got, wordAddr_t want);
		if (got !== want) begin
			abortRun($sformatf("CHECK FAILED %s got %h expected %h", name, got, want));
		end
	endtask

	task automatic checkByteAddr(string name, byteAddr_t got, byteAddr_t want);
		if (got !== want) begin
			abortRun($sformatf("CHECK FAILED %s got %h expected %h", name, got, want));
		end
	endtask

	function automatic xlen_t laneMask(byteEn_t be);
		return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
	endfunction

	task automatic checkResetState();
		checkBit("iMemCsn", iMemCsn, 1'b1);
		checkBit("dMemCsn", dMemCsn, 1'b1);
		checkBit("dMemWen", dMemWen, 1'b1);
		checkBit("halt", halt, 1'b0);
	endtask

	// Checks one instruction mid-cycle before the edge that retires it
	task automatic compareStep();
		instr_t      ins;
		stepResult_t want;
		ins = imem[refPc[11:2]];
		checkByteAddr("iMemAddr", iMemAddr, refPc[11:0]);
		checkBit("iMemCsn", iMemCsn, 1'b0);
		want = rvStep(refPc, ins);
		checkBit("rfWe", rfWe, want.we);
		if (want.we) begin
			checkRegIdx("rfWa", rfWa, want.wa);
			checkWord("outputPort", outputPort, want.wd);
		end
		checkBit("dMemWen", dMemWen, !want.memWrite);
		checkBit("dMemCsn", dMemCsn, !(want.memRead || want.memWrite));
		if (want.memRead || want.memWrite) begin
			checkWordAddr("dMemAddr", dMemAddr, want.addr);
		end
		if (want.memWrite) begin
			checkByteEn("dMemBe", dMemBe, want.be);
			checkWord("dMemDout", dMemDout & laneMask(want.be), want.sdata & laneMask(want.be));
		end
		refPc = want.nextPc;
		retired++;
		refHalted = sawFirst && (ins == HALT_SECOND);
		sawFirst = (ins == HALT_FIRST);
	endtask

	initial begin
		int cycles;
		RSTn = 1'b1;
		seed = 32'h23e97809;
		for (int i = 0; i < 4096; i++) begin
			dmem[i] = $random(seed);
			refMem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) begin
			refRegs[i] = '0;
		end
		buildProgram();
		for (int i = 0; i < 1024; i++) begin
			if (i < testProgram.size()) begin
				imem[i] = testProgram[i];
			end else begin
				// Unused words are no-ops tagged with their index
				imem[i] = encI(OPC_OPIMM, 3'd0, 5'd0, 5'd0, 12'(i));
			end
		end
		refPc = START_PC;
		retired = 0;
		sawFirst = 1'b0;
		refHalted = 1'b0;

		@(posedge CLK);
		repeat (3) begin
			@(negedge CLK);
			checkResetState();
			@(posedge CLK);
		end
		RSTn <= 1'b0;

		cycles = 0;
		@(negedge CLK);
		while (halt !== 1'b1) begin
			if (cycles == TIMEOUT_CYCLES) begin
				abortRun($sformatf("Halt never rose within %0d cycles", TIMEOUT_CYCLES));
			end
			checkBit("halt", halt, refHalted);
			compareStep();
			cycles++;
			@(negedge CLK);
		end
		checkBit("halt", halt, refHalted);

		// Core must stay frozen once halted
		repeat (HOLD_CYCLES) begin
			checkByteAddr("iMemAddr", iMemAddr, refPc[11:0]);
			checkBit("rfWe", rfWe, 1'b0);
			checkBit("dMemWen", dMemWen, 1'b1);
			checkBit("dMemCsn", dMemCsn, 1'b1);
			checkBit("halt", halt, 1'b1);
			@(negedge CLK);
		end
		checkWord("numInst", numInst, xlen_t'(retired));
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- riscvTop.f
+incdir+include
verilog/rvIsaPkg.sv
verilog/rvCorePkg.sv
verilog/regFile.sv
verilog/rvDecoder.sv
verilog/rvAlu.sv
verilog/lsuAlign.sv
verilog/haltMonitor.sv
verilog/riscvCore.sv
verilog/riscvTop.sv
tests/tbRiscvTop.sv
